// File: bench/ifetch_assert.sv
//////////////////////////////
// fetch front end assertions
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module ifetch_assert import ifetch_pkg::*; #(
  parameter int DEPTH = `IF_DEPTH,
  parameter int CW    = $clog2(`IF_DEPTH+1)
) (
  input logic          clk_i,
  input logic          rst_ni,
  input logic          flush_i,
  input logic          req_valid_i,
  input logic [CW-1:0] inflight_i,
  input logic          out_valid_i,
  input logic          out_ready_i,
  input instr_t        out_i
);

  // never more reads outstanding than the buffer can hold
  a_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(inflight_i) <= DEPTH)
    else $error("in-flight count above depth");

  // held output stays put until taken, unless flushed
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(out_i))
    else $error("output changed while stalled");

  a_no_req_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !req_valid_i)
    else $error("request offered in a flush cycle");

endmodule

// in-flight count lives in bus control, output stability at top
bind fetch_bus_ctrl ifetch_assert #(.DEPTH(DEPTH), .CW(CW)) ifetch_assert_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .req_valid_i (bus_req_valid_o),
  .inflight_i  (inflight),
  .out_valid_i (1'b0),
  .out_ready_i (1'b1),
  .out_i       ('0)
);

bind ifetch_top ifetch_assert ifetch_assert_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .req_valid_i (bus_req_valid_o),
  .inflight_i  ('0),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_i       (out_o)
);

// File: bench/ifetch_tb.sv
//////////////////////////////
// fetch front end testbench
// bus memory model and vector driven tests
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module ifetch_tb import ifetch_pkg::*; ();

  // bus model bookkeeping for one accepted read
  typedef struct packed {
    int unsigned   due;   // cycle when the response may go out
    logic [31:0]   addr;
    logic          tag;
  } pend_t;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                flush_i;
  logic [`IF_XLEN-1:0] flush_pc_i;
  logic                bus_req_valid_o;
  bus_req_t            bus_req_o;
  logic                bus_req_ready_i;
  logic                bus_rsp_valid_i;
  bus_rsp_t            bus_rsp_i;
  logic                out_valid_o;
  instr_t              out_o;
  logic                out_ready_i;

  logic [31:0] vec [256];   // whole vector file
  logic [31:0] mem [16];    // bus memory that wraps every 64 bytes
  logic [31:0] err_addr;    // word that answers with an error
  pend_t       pend_q [$];
  integer      seed = 32'h728e_09d9;
  int unsigned cyc_cnt = 0;
  int          n_tests;
  int          total_exp;
  int          errors = 0;
  int          n_checks = 0;

  // sampled on the falling edge and applied on the next rising edge
  logic        req_seen = 1'b0;
  logic [31:0] req_addr_s;
  logic        req_tag_s;
  logic        rdy_s = 1'b0;
  int unsigned lat_s;

  ifetch_top ifetch_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .flush_pc_i      (flush_pc_i),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i),
    .out_valid_o     (out_valid_o),
    .out_o           (out_o),
    .out_ready_i     (out_ready_i)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  //////////////////////////////
  // bus memory model
  //////////////////////////////

  always @(negedge clk_i)
  begin
    req_seen   = bus_req_valid_o && bus_req_ready_i;  // accepted on next edge
    req_addr_s = bus_req_o.addr;
    req_tag_s  = bus_req_o.tag;
    rdy_s      = ({$random(seed)} % 4) != 0;          // ready low about 1 in 4
    lat_s      = {$random(seed)} % 3;                  // 1 to 3 cycles
  end

  always @(posedge clk_i)
  begin : bus_model
    pend_t p;
    cyc_cnt         = cyc_cnt + 1;
    bus_req_ready_i <= rdy_s;
    if (req_seen)
    begin
      p.due  = cyc_cnt + lat_s;
      p.addr = req_addr_s;
      p.tag  = req_tag_s;
      pend_q.push_back(p);
    end
    // in order with at most one response per cycle
    if (pend_q.size() > 0 && pend_q[0].due <= cyc_cnt)
    begin
      p = pend_q.pop_front();
      bus_rsp_valid_i <= 1'b1;
      bus_rsp_i.data  <= mem[p.addr[5:2]];
      bus_rsp_i.tag   <= p.tag;
      bus_rsp_i.err   <= (p.addr == err_addr);
    end
    else
      bus_rsp_valid_i <= 1'b0;
  end

  //////////////////////////////
  // checks and tests
  //////////////////////////////

  function automatic logic [31:0] rec(input int idx);
    return vec[8'(idx)];
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    n_checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  // record holds start pc, flush cycle, flush pc, ready duty, count and (pc|err, instr) pairs
  task automatic run_test(input int t);
    int          base;
    int          n;
    int          got;
    int          cyc;
    int          flush_cyc;
    int          duty;
    int          errs_before;
    logic [31:0] start_pc;
    logic [31:0] flush_pc;
    logic [31:0] exp_pc;
    logic [31:0] exp_ins;
    logic        collecting;
    base        = 32 + 32 * t;
    start_pc    = rec(base);
    flush_cyc   = rec(base + 1);
    flush_pc    = rec(base + 2);
    duty        = rec(base + 3);
    n           = rec(base + 4);
    errs_before = errors;
    got         = 0;
    cyc         = 0;
    collecting  = 1'b0;
    while (got < n)
    begin
      @(posedge clk_i);
      out_ready_i <= ({$random(seed)} % 100) < duty;
      if (cyc == 0)
      begin
        flush_i    <= 1'b1;   // start command
        flush_pc_i <= start_pc;
      end
      else if (cyc == flush_cyc)
      begin
        flush_i    <= 1'b1;   // redirect mid stream
        flush_pc_i <= flush_pc;
      end
      else
        flush_i <= 1'b0;
      @(negedge clk_i);
      // a handshake in a flush cycle is dropped by the queue
      if (flush_i)
        collecting = (flush_cyc == 0) || (cyc == flush_cyc);
      else if (collecting && out_valid_o && out_ready_i)
      begin
        exp_pc  = rec(base + 5 + 2 * got);
        exp_ins = rec(base + 6 + 2 * got);
        check("out_o.pc", out_o.pc, {exp_pc[31:1], 1'b0});
        check("out_o.instr", out_o.instr, exp_ins);
        check("out_o.compressed", {31'b0, out_o.compressed}, {31'b0, exp_ins[1:0] != 2'b11});
        check("out_o.err", {31'b0, out_o.err}, {31'b0, exp_pc[0]});
        got++;
      end
      cyc++;
    end
    $display("test %0d: %0d instructions from pc 0x%h, %s", t, n, start_pc,
             (errors == errs_before) ? "ok" : "with errors");
  endtask

  initial
  begin : main
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    flush_pc_i      = '0;
    bus_req_ready_i = 1'b0;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_i       = '0;
    out_ready_i     = 1'b0;
    $readmemh("bench/ifetch_vectors.txt", vec);
    for (int i = 0; i < 16; i++)
      mem[i] = vec[i];
    err_addr  = vec[16];
    n_tests   = vec[17];
    total_exp = 0;
    for (int t = 0; t < n_tests; t++)
      total_exp += rec(32 + 32 * t + 4);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < n_tests; t++)
      run_test(t);
    $display("done: %0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog allows 200 cycles per expected instruction
  initial
  begin : watchdog
    @(posedge rst_ni);
    repeat (200 * total_exp) @(posedge clk_i);
    $display("watchdog expired: the DUT stopped delivering instructions");
    $display("sim failed");
    $finish;
  end

endmodule

// File: bench/ifetch_vectors.txt
// @00 memory words 0x00..0x3c, @10 error address and test count
// @20 + 0x20*n test n: start pc, flush cycle, flush pc, ready percent, count, (pc|err, instr) pairs
@00
00100093 00200113 00308193 00418213
05054501 02934585 460900a0 00c58693
07934705 80820010 00f70733 00008067
00000013 00000013 00000013 00000013
@10
00000024 00000006
// aligned 32 bit stream
@20
00000000 00000000 00000000 00000064 00000004
00000000 00100093 00000004 00200113 00000008 00308193 0000000c 00418213
// mixed code with a straddling instruction
@40
00000010 00000000 00000000 00000064 00000006
00000010 00004501 00000012 00000505 00000014 00004585
00000016 00a00293 0000001a 00004609 0000001c 00c58693
// start on the upper halfword
@60
00000012 00000000 00000000 00000064 00000005
00000012 00000505 00000014 00004585 00000016 00a00293 0000001a 00004609 0000001c 00c58693
// flush at cycle 4 to 0x17, bit 0 dropped
@80
00000000 00000004 00000017 00000064 00000003
00000016 00a00293 0000001a 00004609 0000001c 00c58693
// 40 percent ready
@a0
00000010 00000000 00000000 00000028 00000006
00000010 00004501 00000012 00000505 00000014 00004585
00000016 00a00293 0000001a 00004609 0000001c 00c58693
// error word at 0x24
@c0
00000020 00000000 00000000 00000046 00000005
00000020 00004705 00000023 00100793 00000027 00008082 00000028 00f70733 0000002c 00008067

// File: include/ifetch_defines.svh
//////////////////////////////
// fetch front end sizing
// widths and depths shared by package and rtl
//////////////////////////////

`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// bus data width, also the instruction word width
`define IF_XLEN 32

// max bus reads in flight, also the response buffer size
`define IF_DEPTH 2

// entries in the instruction queue toward decode
`define IF_QDEPTH 4

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module ifetch_tb \
  -Mdir obj_dir -o ifetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ifetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// File: source/fetch_bus_ctrl.sv
//////////////////////////////
// fetch bus control
// pipelined reads, flush discard and word buffer
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module fetch_bus_ctrl import ifetch_pkg::*; #(
  parameter int DEPTH = `IF_DEPTH  // reads in flight plus buffered words
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic [`IF_XLEN-1:0] flush_pc_i,
  output logic                bus_req_valid_o,
  output bus_req_t            bus_req_o,
  input  logic                bus_req_ready_i,
  input  logic                bus_rsp_valid_i,
  input  bus_rsp_t            bus_rsp_i,
  output logic                word_valid_o,
  output fetch_word_t         word_o,
  input  logic                word_ready_i
);

  localparam int CW = $clog2(DEPTH+1);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [CW:0] DEPTH_W = (CW+1)'(DEPTH);

  logic                started_q;   // set by the first flush
  logic [`IF_XLEN-3:0] req_addr_q;  // next word to request
  logic                req_tag_q;
  logic [`IF_XLEN-3:0] rsp_addr_q;  // word address of next kept response
  logic [CW-1:0]       inflight;
  logic [CW-1:0]       discard;
  logic [CW-1:0]       buf_cnt;
  logic [PW-1:0]       wr_ptr;
  logic [PW-1:0]       rd_ptr;
  logic [CW:0]         occ;
  logic                req_fire;
  logic                rsp_keep;
  logic                pop;
  fetch_word_t         rsp_word;
  fetch_word_t         buf_mem [DEPTH];

  //////////////////////////////
  // request side
  //////////////////////////////

  assign occ             = {1'b0, inflight} + {1'b0, buf_cnt};
  assign bus_req_valid_o = started_q & ~flush_i & (occ < DEPTH_W);
  assign bus_req_o.addr  = {req_addr_q, 2'b00};  // always word aligned
  assign bus_req_o.tag   = req_tag_q;
  assign req_fire        = bus_req_valid_o & bus_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      started_q  <= 1'b0;
      req_addr_q <= '0;
      req_tag_q  <= 1'b0;
    end
    else if (flush_i)
    begin
      started_q  <= 1'b1;
      req_addr_q <= flush_pc_i[`IF_XLEN-1:2];
      req_tag_q  <= flush_pc_i[1];  // bit 0 ignored
    end
    else if (req_fire)
    begin
      req_addr_q <= req_addr_q + 1'b1;
      req_tag_q  <= 1'b0;           // later words start at halfword 0
    end
  end

  // one response per accepted request, discarded ones included
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight <= '0;
    else
      case ({req_fire, bus_rsp_valid_i})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: ;
      endcase
  end

  // stale responses, minus one landing in the flush cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard <= '0;
    else if (flush_i)
      discard <= inflight - CW'(bus_rsp_valid_i);
    else if (|discard && bus_rsp_valid_i)
      discard <= discard - 1'b1;
  end

  //////////////////////////////
  // response buffer
  //////////////////////////////

  assign rsp_keep = bus_rsp_valid_i & ~flush_i & ~|discard;
  assign pop      = word_valid_o & word_ready_i;

  always_comb
  begin
    rsp_word.data.word = bus_rsp_i.data;
    rsp_word.waddr     = rsp_addr_q;
    rsp_word.tag       = bus_rsp_i.tag;
    rsp_word.err       = bus_rsp_i.err;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rsp_addr_q <= '0;
      buf_cnt    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
    end
    else if (flush_i)
    begin
      rsp_addr_q <= flush_pc_i[`IF_XLEN-1:2];
      buf_cnt    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
    end
    else
    begin
      if (rsp_keep)
      begin
        rsp_addr_q <= rsp_addr_q + 1'b1;
        wr_ptr     <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({rsp_keep, pop})
        2'b10:   buf_cnt <= buf_cnt + 1'b1;
        2'b01:   buf_cnt <= buf_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rsp_keep)
      buf_mem[wr_ptr] <= rsp_word;
  end

  assign word_valid_o = |buf_cnt;
  assign word_o       = buf_mem[rd_ptr];

endmodule

// File: source/ifetch_pkg.sv
//////////////////////////////
// fetch front end types
//////////////////////////////

`include "ifetch_defines.svh"

package ifetch_pkg;

  // read request, word aligned
  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
    logic                tag;   // pc bit 1, start halfword
  } bus_req_t;

  typedef struct packed {
    logic [`IF_XLEN-1:0] data;
    logic                tag;   // echoed from request
    logic                err;   // bus error on this word
  } bus_rsp_t;

  typedef struct packed {
    logic [`IF_XLEN/2-1:0] hi;
    logic [`IF_XLEN/2-1:0] lo;
  } parcel_pair_t;

  // one fetched word, whole or as two 16 bit parcels
  typedef union packed {
    logic [`IF_XLEN-1:0] word;
    parcel_pair_t        half;
  } parcel_u;

  typedef struct packed {
    parcel_u               data;
    logic [`IF_XLEN-3:0]   waddr;  // word address, pc[31:2]
    logic                  tag;    // start at hi parcel
    logic                  err;
  } fetch_word_t;

  // assembled instruction, upper half zero when compressed
  typedef struct packed {
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] instr;
    logic                compressed;
    logic                err;
  } instr_t;

endpackage

// File: source/ifetch_top.sv
//////////////////////////////
// instruction fetch front end
// bus control, parcel alignment, queue
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module ifetch_top import ifetch_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,     // also the start command
  input  logic [`IF_XLEN-1:0] flush_pc_i,
  output logic                bus_req_valid_o,
  output bus_req_t            bus_req_o,
  input  logic                bus_req_ready_i,
  input  logic                bus_rsp_valid_i,
  input  bus_rsp_t            bus_rsp_i,
  output logic                out_valid_o,
  output instr_t              out_o,
  input  logic                out_ready_i
);

  logic        word_valid;
  fetch_word_t word;
  logic        word_ready;
  logic        ins_valid;
  instr_t      ins;
  logic        ins_ready;

  fetch_bus_ctrl #(
    .DEPTH (`IF_DEPTH)
  ) fetch_bus_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .flush_pc_i      (flush_pc_i),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i),
    .word_valid_o    (word_valid),
    .word_o          (word),
    .word_ready_i    (word_ready)
  );

  parcel_align parcel_align_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .word_valid_i (word_valid),
    .word_i       (word),
    .word_ready_o (word_ready),
    .ins_valid_o  (ins_valid),
    .ins_o        (ins),
    .ins_ready_i  (ins_ready)
  );

  instr_queue #(
    .DEPTH (`IF_QDEPTH)
  ) instr_queue_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .ins_valid_i (ins_valid),
    .ins_i       (ins),
    .ins_ready_o (ins_ready),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// File: source/instr_queue.sv
//////////////////////////////
// instruction queue toward decode
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module instr_queue import ifetch_pkg::*; #(
  parameter int DEPTH = `IF_QDEPTH
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   ins_valid_i,
  input  instr_t ins_i,
  output logic   ins_ready_o,
  output logic   out_valid_o,
  output instr_t out_o,
  input  logic   out_ready_i
);

  localparam int CW = $clog2(DEPTH+1);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  instr_t        mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          push;
  logic          pop;

  assign ins_ready_o = cnt != CW'(DEPTH);
  assign out_valid_o = |cnt;
  assign out_o       = mem[rd_ptr];
  assign push        = ins_valid_i & ins_ready_o & ~flush_i;  // flush wins
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr] <= ins_i;
  end

endmodule

// File: source/parcel_align.sv
//////////////////////////////
// parcel alignment
// builds 16/32 bit instructions from fetched words
//////////////////////////////

`timescale 1ns/1ps

`include "ifetch_defines.svh"

module parcel_align import ifetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        word_valid_i,
  input  fetch_word_t word_i,
  output logic        word_ready_o,
  output logic        ins_valid_o,
  output instr_t      ins_o,
  input  logic        ins_ready_i
);

  localparam int HW = `IF_XLEN/2;

  logic                lv_q;       // leftover low parcel of a 32 bit instr
  logic [HW-1:0]       lv_parcel;
  logic [`IF_XLEN-1:0] lv_pc;
  logic                lv_err;
  logic                pos_q;      // lo parcel of current word already used
  logic                hsel;
  logic                lo_c;
  logic                hi_c;
  logic                tail;       // hi parcel still pending after emit
  logic                keep_hi;
  logic                ins_fire;
  logic                word_fire;

  assign hsel = pos_q | word_i.tag;
  assign lo_c = word_i.data.half.lo[1:0] != 2'b11;  // compressed parcel
  assign hi_c = word_i.data.half.hi[1:0] != 2'b11;

  always_comb
  begin
    ins_valid_o = 1'b0;
    ins_o       = '0;
    tail        = 1'b0;
    if (word_valid_i)
    begin
      if (lv_q)
      begin
        // 32 bit instr straddling the word boundary
        ins_valid_o    = 1'b1;
        ins_o.pc       = lv_pc;
        ins_o.instr    = {word_i.data.half.lo, lv_parcel};
        ins_o.err      = lv_err | word_i.err;
        tail           = 1'b1;
      end
      else if (!hsel)
      begin
        ins_valid_o = 1'b1;
        ins_o.pc    = {word_i.waddr, 2'b00};
        ins_o.err   = word_i.err;
        if (lo_c)
        begin
          ins_o.instr      = {{HW{1'b0}}, word_i.data.half.lo};
          ins_o.compressed = 1'b1;
          tail             = 1'b1;
        end
        else
          ins_o.instr = word_i.data.word;  // aligned full word
      end
      else if (hi_c)
      begin
        // compressed instr in the hi parcel
        ins_valid_o      = 1'b1;
        ins_o.pc         = {word_i.waddr, 2'b10};
        ins_o.instr      = {{HW{1'b0}}, word_i.data.half.hi};
        ins_o.compressed = 1'b1;
        ins_o.err        = word_i.err;
      end
    end
  end

  // take the word once its last parcel is used or kept
  always_comb
  begin
    if (tail)
      word_ready_o = ins_ready_i & ~hi_c;
    else if (hsel && !hi_c)
      word_ready_o = 1'b1;               // only stash the hi parcel
    else
      word_ready_o = ins_ready_i;
  end

  assign keep_hi   = (tail | hsel) & ~hi_c;
  assign ins_fire  = ins_valid_o & ins_ready_i;
  assign word_fire = word_valid_i & word_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lv_q  <= 1'b0;
      pos_q <= 1'b0;
    end
    else if (flush_i)
    begin
      lv_q  <= 1'b0;
      pos_q <= 1'b0;
    end
    else if (word_fire)
    begin
      lv_q  <= keep_hi;
      pos_q <= 1'b0;
    end
    else if (ins_fire)
    begin
      lv_q  <= 1'b0;
      pos_q <= 1'b1;  // second compressed instr next cycle
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (word_fire && keep_hi)
    begin
      lv_parcel <= word_i.data.half.hi;
      lv_pc     <= {word_i.waddr, 2'b10};
      lv_err    <= word_i.err;
    end
  end

endmodule

// File: src.f
+incdir+include
source/ifetch_pkg.sv
source/fetch_bus_ctrl.sv
source/parcel_align.sv
source/instr_queue.sv
source/ifetch_top.sv
bench/ifetch_assert.sv
bench/ifetch_tb.sv
